// File: hw/axi_mem_pkg.sv
// Shared AXI4 channel types and RAM geometry; 32-bit data only, 1024-word RAM, IDs not carried
package axi_mem_pkg;

    // RAM geometry in 32-bit words
    localparam int unsigned RAM_WORDS = 1024;
    localparam int unsigned ADDR_W = $clog2(RAM_WORDS);

    // Encoded AWSIZE/ARSIZE for 4-byte beats
    localparam logic [2:0] AXI_SIZE_4B = 3'd2;

    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'd0,
        AXI_BURST_INCR  = 2'd1,
        AXI_BURST_WRAP  = 2'd2
    } axi_burst_e;

    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'd0,
        AXI_RESP_EXOKAY = 2'd1,
        AXI_RESP_SLVERR = 2'd2,
        AXI_RESP_DECERR = 2'd3
    } axi_resp_e;

    // Write address, byte addressed
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        axi_burst_e  burst;
    } axi_aw_t;

    // Read address, same layout as write address
    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
    } axi_r_t;

    // External command, word addressed, len is beat count minus one
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
    } mem_cmd_t;

    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
    } read_beat_t;

endpackage

// File: hw/bram_1r1w.sv
// Block RAM with one write and one registered read port; no init contents, read-during-write gives old data
`timescale 1ns/1ps

module bram_1r1w #(
    parameter int ADDR_WIDTH = 10,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output logic [DATA_WIDTH-1:0] rd_data
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle read latency, port always enabled
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hw/data_ram.sv
// AXI4 slave RAM for 32-bit INCR bursts only; ID, size, burst type and strobes are ignored
`timescale 1ns/1ps

module data_ram (
    input  logic                 clk,
    input  logic                 rst,
    input  axi_mem_pkg::axi_aw_t aw,
    input  logic                 aw_valid,
    output logic                 aw_ready,
    input  axi_mem_pkg::axi_w_t  w,
    input  logic                 w_valid,
    output logic                 w_ready,
    output axi_mem_pkg::axi_b_t  b,
    output logic                 b_valid,
    input  logic                 b_ready,
    input  axi_mem_pkg::axi_ar_t ar,
    input  logic                 ar_valid,
    output logic                 ar_ready,
    output axi_mem_pkg::axi_r_t  r,
    output logic                 r_valid,
    input  logic                 r_ready
);
    import axi_mem_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_START,
        WR_BURST,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_START,
        RD_BURST
    } rd_state_e;

    wr_state_e         wr_state;
    logic              aw_ready_reg;
    logic              w_ready_reg;
    logic              b_valid_reg;
    logic [ADDR_W-1:0] wr_addr_reg;
    logic              wr_err_reg;
    logic [31:0]       aw_last_word;
    logic              ram_wr_en;

    rd_state_e         rd_state;
    logic              ar_ready_reg;
    logic              r_valid_reg;
    logic              r_last_reg;
    logic              rd_err_reg;
    logic [ADDR_W-1:0] rd_addr_reg;
    logic [7:0]        rd_len_reg;
    logic [31:0]       ar_last_word;
    logic [ADDR_W-1:0] ram_rd_addr;
    logic [31:0]       ram_rd_data;

    // Word index of the final beat; covers the first word too since len is never negative
    assign aw_last_word = {2'b00, aw.addr[31:2]} + {24'h0, aw.len};
    assign ar_last_word = {2'b00, ar.addr[31:2]} + {24'h0, ar.len};

    assign ram_wr_en = w_valid && w_ready_reg && !wr_err_reg;

    // Look ahead to the next word on a transfer so beats stream back to back
    assign ram_rd_addr = (r_valid_reg && r_ready) ? rd_addr_reg + ADDR_W'(1) : rd_addr_reg;

    bram_1r1w #(
        .ADDR_WIDTH(ADDR_W),
        .DATA_WIDTH(32)
    ) ram_inst (
        .clk    (clk),
        .wr_en  (ram_wr_en),
        .wr_addr(wr_addr_reg),
        .wr_data(w.data),
        .rd_addr(ram_rd_addr),
        .rd_data(ram_rd_data)
    );

    // Write FSM
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_state <= WR_IDLE;
            aw_ready_reg <= 1'b0;
            w_ready_reg <= 1'b0;
            b_valid_reg <= 1'b0;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    aw_ready_reg <= 1'b1;
                    if (aw_valid && aw_ready_reg) begin
                        aw_ready_reg <= 1'b0;
                        wr_state <= WR_START;
                    end
                end
                WR_START: begin
                    w_ready_reg <= 1'b1;
                    wr_state <= WR_BURST;
                end
                WR_BURST: begin
                    if (w_valid && w.last) begin
                        w_ready_reg <= 1'b0;
                        b_valid_reg <= 1'b1;
                        wr_state <= WR_RESP;
                    end
                end
                default: begin
                    if (b_ready) begin
                        b_valid_reg <= 1'b0;
                        aw_ready_reg <= 1'b1;
                        wr_state <= WR_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready_reg) begin
            wr_addr_reg <= aw.addr[ADDR_W+1:2];
            wr_err_reg <= aw_last_word >= RAM_WORDS;
        end else if (w_valid && w_ready_reg) begin
            wr_addr_reg <= wr_addr_reg + ADDR_W'(1);
        end
    end

    // Read FSM
    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_state <= RD_IDLE;
            ar_ready_reg <= 1'b0;
            r_valid_reg <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    ar_ready_reg <= 1'b1;
                    if (ar_valid && ar_ready_reg) begin
                        ar_ready_reg <= 1'b0;
                        rd_state <= RD_START;
                    end
                end
                RD_START: begin
                    // First word is being read from the RAM here
                    r_valid_reg <= 1'b1;
                    rd_state <= RD_BURST;
                end
                default: begin
                    if (r_ready && r_last_reg) begin
                        r_valid_reg <= 1'b0;
                        ar_ready_reg <= 1'b1;
                        rd_state <= RD_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready_reg) begin
            rd_addr_reg <= ar.addr[ADDR_W+1:2];
            rd_len_reg <= ar.len;
            rd_err_reg <= ar_last_word >= RAM_WORDS;
            r_last_reg <= ar.len == 8'd0;
        end else if (r_valid_reg && r_ready) begin
            rd_addr_reg <= ram_rd_addr;
            rd_len_reg <= rd_len_reg - 8'd1;
            r_last_reg <= rd_len_reg == 8'd1;
        end
    end

    assign aw_ready = aw_ready_reg;
    assign w_ready = w_ready_reg;
    assign b_valid = b_valid_reg;
    assign b.resp = wr_err_reg ? AXI_RESP_SLVERR : AXI_RESP_OKAY;

    assign ar_ready = ar_ready_reg;
    assign r_valid = r_valid_reg;
    assign r.data = rd_err_reg ? 32'h0 : ram_rd_data;
    assign r.resp = rd_err_reg ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    assign r.last = r_last_reg;

endmodule

// File: hw/burst_writer.sv
// AXI4 write master, one INCR burst of 32-bit words in flight, full strobes, data stream must supply len+1 words
`timescale 1ns/1ps

module burst_writer (
    input  logic                   clk,
    input  logic                   rst,
    input  axi_mem_pkg::mem_cmd_t  wr_cmd,
    input  logic                   wr_cmd_valid,
    output logic                   wr_cmd_ready,
    input  logic [31:0]            wr_data,
    input  logic                   wr_data_valid,
    output logic                   wr_data_ready,
    output logic                   wr_done,
    output axi_mem_pkg::axi_resp_e wr_resp,
    output axi_mem_pkg::axi_aw_t   aw,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output axi_mem_pkg::axi_w_t    w,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  axi_mem_pkg::axi_b_t    b,
    input  logic                   b_valid,
    output logic                   b_ready
);
    import axi_mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } state_e;

    state_e      state;
    logic        cmd_ready_reg;
    logic        aw_valid_reg;
    logic        b_ready_reg;
    logic [31:0] addr_reg;
    logic [7:0]  len_reg;
    logic [7:0]  beat_cnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
            cmd_ready_reg <= 1'b0;
            aw_valid_reg <= 1'b0;
            b_ready_reg <= 1'b0;
        end else begin
            b_ready_reg <= 1'b1;
            case (state)
                IDLE: begin
                    cmd_ready_reg <= 1'b1;
                    if (wr_cmd_valid && cmd_ready_reg) begin
                        cmd_ready_reg <= 1'b0;
                        aw_valid_reg <= 1'b1;
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (aw_ready) begin
                        aw_valid_reg <= 1'b0;
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (w_valid && w_ready && w.last) begin
                        state <= RESP;
                    end
                end
                default: begin
                    if (wr_done) begin
                        cmd_ready_reg <= 1'b1;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Command latch and beat counter
    always_ff @(posedge clk) begin
        if (wr_cmd_valid && cmd_ready_reg) begin
            addr_reg <= wr_cmd.addr;
            len_reg <= wr_cmd.len;
            beat_cnt <= 8'd0;
        end else if (w_valid && w_ready) begin
            beat_cnt <= beat_cnt + 8'd1;
        end
    end

    assign wr_cmd_ready = cmd_ready_reg;

    // Word address to byte address
    assign aw.addr = {addr_reg[29:0], 2'b00};
    assign aw.len = len_reg;
    assign aw.size = AXI_SIZE_4B;
    assign aw.burst = AXI_BURST_INCR;
    assign aw_valid = aw_valid_reg;

    assign w.data = wr_data;
    assign w.strb = 4'hf;
    assign w.last = beat_cnt == len_reg;
    assign w_valid = (state == DATA) && wr_data_valid;
    assign wr_data_ready = (state == DATA) && w_ready;

    assign b_ready = b_ready_reg;
    assign wr_done = (state == RESP) && b_valid && b_ready_reg;
    assign wr_resp = b.resp;

endmodule

// File: hw/burst_reader.sv
// AXI4 read master, one INCR burst of 32-bit words in flight; beats pass through under consumer back-pressure
`timescale 1ns/1ps

module burst_reader (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_mem_pkg::mem_cmd_t   rd_cmd,
    input  logic                    rd_cmd_valid,
    output logic                    rd_cmd_ready,
    output axi_mem_pkg::read_beat_t rd_beat,
    output logic                    rd_beat_valid,
    input  logic                    rd_beat_ready,
    output axi_mem_pkg::axi_ar_t    ar,
    output logic                    ar_valid,
    input  logic                    ar_ready,
    input  axi_mem_pkg::axi_r_t     r,
    input  logic                    r_valid,
    output logic                    r_ready
);
    import axi_mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } state_e;

    state_e      state;
    logic        cmd_ready_reg;
    logic        ar_valid_reg;
    logic [31:0] addr_reg;
    logic [7:0]  len_reg;
    logic        data_phase;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= IDLE;
            cmd_ready_reg <= 1'b0;
            ar_valid_reg <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    cmd_ready_reg <= 1'b1;
                    if (rd_cmd_valid && cmd_ready_reg) begin
                        cmd_ready_reg <= 1'b0;
                        ar_valid_reg <= 1'b1;
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (ar_ready) begin
                        ar_valid_reg <= 1'b0;
                        state <= DATA;
                    end
                end
                default: begin
                    // Burst ends with the last beat handed downstream
                    if (r_valid && r_ready && r.last) begin
                        cmd_ready_reg <= 1'b1;
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_cmd_valid && cmd_ready_reg) begin
            addr_reg <= rd_cmd.addr;
            len_reg <= rd_cmd.len;
        end
    end

    assign rd_cmd_ready = cmd_ready_reg;

    assign ar.addr = {addr_reg[29:0], 2'b00};
    assign ar.len = len_reg;
    assign ar.size = AXI_SIZE_4B;
    assign ar.burst = AXI_BURST_INCR;
    assign ar_valid = ar_valid_reg;

    assign data_phase = state == DATA;

    // R maps one to one onto output beats
    assign rd_beat.data = r.data;
    assign rd_beat.resp = r.resp;
    assign rd_beat.last = r.last;
    assign rd_beat_valid = data_phase && r_valid;
    assign r_ready = data_phase && rd_beat_ready;

endmodule

// File: hw/axi_mem_top.sv
// Writer, AXI4 RAM and reader joined by AXI4 channels; a write ends at wr_done, a read at the last beat
`timescale 1ns/1ps

module axi_mem_top (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_mem_pkg::mem_cmd_t   wr_cmd,
    input  logic                    wr_cmd_valid,
    output logic                    wr_cmd_ready,
    input  logic [31:0]             wr_data,
    input  logic                    wr_data_valid,
    output logic                    wr_data_ready,
    output logic                    wr_done,
    output axi_mem_pkg::axi_resp_e  wr_resp,
    input  axi_mem_pkg::mem_cmd_t   rd_cmd,
    input  logic                    rd_cmd_valid,
    output logic                    rd_cmd_ready,
    output axi_mem_pkg::read_beat_t rd_beat,
    output logic                    rd_beat_valid,
    input  logic                    rd_beat_ready
);
    import axi_mem_pkg::*;

    // Write side channels
    axi_aw_t aw;
    logic    aw_valid;
    logic    aw_ready;
    axi_w_t  w;
    logic    w_valid;
    logic    w_ready;
    axi_b_t  b;
    logic    b_valid;
    logic    b_ready;

    // Read side channels
    axi_ar_t ar;
    logic    ar_valid;
    logic    ar_ready;
    axi_r_t  r;
    logic    r_valid;
    logic    r_ready;

    burst_writer writer_inst (
        .clk          (clk),
        .rst          (rst),
        .wr_cmd       (wr_cmd),
        .wr_cmd_valid (wr_cmd_valid),
        .wr_cmd_ready (wr_cmd_ready),
        .wr_data      (wr_data),
        .wr_data_valid(wr_data_valid),
        .wr_data_ready(wr_data_ready),
        .wr_done      (wr_done),
        .wr_resp      (wr_resp),
        .aw           (aw),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w            (w),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .b            (b),
        .b_valid      (b_valid),
        .b_ready      (b_ready)
    );

    data_ram ram_inst (
        .clk     (clk),
        .rst     (rst),
        .aw      (aw),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .w       (w),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .b       (b),
        .b_valid (b_valid),
        .b_ready (b_ready),
        .ar      (ar),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .r       (r),
        .r_valid (r_valid),
        .r_ready (r_ready)
    );

    burst_reader reader_inst (
        .clk          (clk),
        .rst          (rst),
        .rd_cmd       (rd_cmd),
        .rd_cmd_valid (rd_cmd_valid),
        .rd_cmd_ready (rd_cmd_ready),
        .rd_beat      (rd_beat),
        .rd_beat_valid(rd_beat_valid),
        .rd_beat_ready(rd_beat_ready),
        .ar           (ar),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .r            (r),
        .r_valid      (r_valid),
        .r_ready      (r_ready)
    );

endmodule

// File: sim/axi_mem_assertions.sv
// Handshake rules on the internal AXI channels; bound into axi_mem_top, failures raised by $error only
`timescale 1ns/1ps

module axi_mem_assertions (
    input logic                 clk,
    input logic                 rst,
    input axi_mem_pkg::axi_aw_t aw,
    input logic                 aw_valid,
    input logic                 aw_ready,
    input axi_mem_pkg::axi_w_t  w,
    input logic                 w_valid,
    input logic                 w_ready,
    input axi_mem_pkg::axi_b_t  b,
    input logic                 b_valid,
    input logic                 b_ready,
    input axi_mem_pkg::axi_ar_t ar,
    input logic                 ar_valid,
    input logic                 ar_ready,
    input axi_mem_pkg::axi_r_t  r,
    input logic                 r_valid,
    input logic                 r_ready
);
    import axi_mem_pkg::*;

    int   assert_errors = 0;
    logic w_last_seen;

    // Set by the closing W beat, cleared by the B transfer
    always @(posedge clk) begin
        if (!rst) begin
            w_last_seen <= 1'b0;
        end else if (w_valid && w_ready && w.last) begin
            w_last_seen <= 1'b1;
        end else if (b_valid && b_ready) begin
            w_last_seen <= 1'b0;
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else begin
        $error("AW valid dropped or payload changed before transfer");
        assert_errors++;
    end

    w_hold: assert property (@(posedge clk) disable iff (!rst)
        w_valid && !w_ready |=> w_valid && $stable(w))
    else begin
        $error("W valid dropped or payload changed before transfer");
        assert_errors++;
    end

    b_hold: assert property (@(posedge clk) disable iff (!rst)
        b_valid && !b_ready |=> b_valid && $stable(b))
    else begin
        $error("B valid dropped or payload changed before transfer");
        assert_errors++;
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else begin
        $error("AR valid dropped or payload changed before transfer");
        assert_errors++;
    end

    r_hold: assert property (@(posedge clk) disable iff (!rst)
        r_valid && !r_ready |=> r_valid && $stable(r))
    else begin
        $error("R valid dropped or payload changed before transfer");
        assert_errors++;
    end

    b_after_last: assert property (@(posedge clk) disable iff (!rst)
        $rose(b_valid) |-> w_last_seen)
    else begin
        $error("B valid rose without a preceding W beat with last");
        assert_errors++;
    end

endmodule

// File: sim/axi_mem_checker.sv
// Scoreboard on the top-level ports; expected response per command comes in on exp_resp with the command
`timescale 1ns/1ps

module axi_mem_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_mem_pkg::mem_cmd_t   wr_cmd,
    input  logic                    wr_cmd_valid,
    input  logic                    wr_cmd_ready,
    input  logic [31:0]             wr_data,
    input  logic                    wr_data_valid,
    input  logic                    wr_data_ready,
    input  logic                    wr_done,
    input  axi_mem_pkg::axi_resp_e  wr_resp,
    input  axi_mem_pkg::mem_cmd_t   rd_cmd,
    input  logic                    rd_cmd_valid,
    input  logic                    rd_cmd_ready,
    input  axi_mem_pkg::read_beat_t rd_beat,
    input  logic                    rd_beat_valid,
    input  logic                    rd_beat_ready,
    input  axi_mem_pkg::axi_resp_e  exp_resp,
    output int                      value_errors,
    output int                      flow_errors
);
    import axi_mem_pkg::*;

    logic [31:0] ref_mem [RAM_WORDS];
    logic [31:0] wr_ptr;
    logic [31:0] rd_ptr;
    logic [7:0]  rd_len;
    int          beat_idx;
    axi_resp_e   wr_exp;
    axi_resp_e   rd_exp;
    logic        reset_edge_seen;
    logic [31:0] exp_data;

    initial begin
        value_errors = 0;
        flow_errors = 0;
        reset_edge_seen = 1'b0;
    end

    task automatic expect_low(input string name, input logic actual);
        if (actual !== 1'b0) begin
            $display("[ERROR] %0t ns: %s expected 0, got %b", $time, name, actual);
            value_errors++;
        end
    endtask

    // Outputs during reset, once the first reset edge has passed
    always @(negedge clk) begin
        if (!rst && reset_edge_seen) begin
            expect_low("wr_cmd_ready", wr_cmd_ready);
            expect_low("wr_data_ready", wr_data_ready);
            expect_low("wr_done", wr_done);
            expect_low("rd_cmd_ready", rd_cmd_ready);
            expect_low("rd_beat_valid", rd_beat_valid);
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            reset_edge_seen = 1'b1;
        end else begin
            if (wr_cmd_valid && wr_cmd_ready) begin
                wr_ptr = wr_cmd.addr;
                wr_exp = exp_resp;
            end
            // Rejected bursts leave the reference untouched
            if (wr_data_valid && wr_data_ready) begin
                if (wr_exp == AXI_RESP_OKAY) begin
                    ref_mem[wr_ptr[ADDR_W-1:0]] = wr_data;
                end
                wr_ptr = wr_ptr + 32'd1;
            end
            if (wr_done && wr_resp !== wr_exp) begin
                $display("[ERROR] %0t ns: wr_resp expected %h, got %h", $time, wr_exp, wr_resp);
                value_errors++;
            end
            if (rd_cmd_valid && rd_cmd_ready) begin
                rd_ptr = rd_cmd.addr;
                rd_len = rd_cmd.len;
                rd_exp = exp_resp;
                beat_idx = 0;
            end
            if (rd_beat_valid && rd_beat_ready) begin
                exp_data = (rd_exp == AXI_RESP_OKAY) ? ref_mem[rd_ptr[ADDR_W-1:0]] : 32'h0;
                if (rd_beat.data !== exp_data) begin
                    $display("[ERROR] %0t ns: rd_beat.data expected %h, got %h",
                             $time, exp_data, rd_beat.data);
                    value_errors++;
                end
                if (rd_beat.resp !== rd_exp) begin
                    $display("[ERROR] %0t ns: rd_beat.resp expected %h, got %h",
                             $time, rd_exp, rd_beat.resp);
                    value_errors++;
                end
                if (rd_beat.last === 1'b1 && beat_idx != rd_len) begin
                    $display("Read burst ended early: last flag on beat %0d of %0d at %0t ns",
                             beat_idx + 1, rd_len + 1, $time);
                    flow_errors++;
                end else if (rd_beat.last !== 1'b1 && beat_idx == rd_len) begin
                    $display("Read burst missing its last flag on final beat %0d at %0t ns",
                             beat_idx + 1, $time);
                    flow_errors++;
                end
                rd_ptr = rd_ptr + 32'd1;
                beat_idx++;
            end
        end
    end

endmodule

// File: sim/axi_mem_tb.sv
// Runs a fixed command table through axi_mem_top with random data and read back-pressure
`timescale 1ns/1ps

module axi_mem_tb;
    import axi_mem_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS = 12;
    localparam logic [31:0] SEED = 32'h7024_2b25;

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;
        logic [7:0]  len;
        axi_resp_e   resp;
    } test_entry_t;

    logic       clk;
    logic       rst;
    mem_cmd_t   wr_cmd;
    logic       wr_cmd_valid;
    logic       wr_cmd_ready;
    logic [31:0] wr_data;
    logic       wr_data_valid;
    logic       wr_data_ready;
    logic       wr_done;
    axi_resp_e  wr_resp;
    mem_cmd_t   rd_cmd;
    logic       rd_cmd_valid;
    logic       rd_cmd_ready;
    read_beat_t rd_beat;
    logic       rd_beat_valid;
    logic       rd_beat_ready;
    axi_resp_e  exp_resp;
    int         value_errors;
    int         flow_errors;

    // Word address, beats minus one, response by the range rule
    function automatic test_entry_t table_row(input int idx);
        test_entry_t row;
        case (idx)
            0:  row = '{OP_WRITE, 32'd5,    8'd0,  AXI_RESP_OKAY};
            1:  row = '{OP_READ,  32'd5,    8'd0,  AXI_RESP_OKAY};
            2:  row = '{OP_WRITE, 32'd100,  8'd15, AXI_RESP_OKAY};
            3:  row = '{OP_READ,  32'd100,  8'd15, AXI_RESP_OKAY};
            4:  row = '{OP_WRITE, 32'd200,  8'd7,  AXI_RESP_OKAY};
            5:  row = '{OP_WRITE, 32'd204,  8'd7,  AXI_RESP_OKAY};
            6:  row = '{OP_READ,  32'd200,  8'd11, AXI_RESP_OKAY};
            7:  row = '{OP_WRITE, 32'd1016, 8'd7,  AXI_RESP_OKAY};
            8:  row = '{OP_WRITE, 32'd1020, 8'd7,  AXI_RESP_SLVERR};
            9:  row = '{OP_READ,  32'd1016, 8'd7,  AXI_RESP_OKAY};
            10: row = '{OP_READ,  32'd1030, 8'd3,  AXI_RESP_SLVERR};
            default: row = '{OP_READ, 32'd1020, 8'd7, AXI_RESP_SLVERR};
        endcase
        return row;
    endfunction

    axi_mem_top axi_mem_top_inst (.*);

    axi_mem_checker checker_inst (.*);

    bind axi_mem_top axi_mem_assertions assertions_inst (.*);

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic run_write(input test_entry_t row);
        int beat;
        wr_cmd.addr <= row.addr;
        wr_cmd.len <= row.len;
        exp_resp <= row.resp;
        wr_cmd_valid <= 1'b1;
        @(posedge clk);
        while (!wr_cmd_ready) @(posedge clk);
        wr_cmd_valid <= 1'b0;
        for (beat = 0; beat <= row.len; beat++) begin
            wr_data <= $urandom;
            wr_data_valid <= 1'b1;
            @(posedge clk);
            while (!wr_data_ready) @(posedge clk);
        end
        wr_data_valid <= 1'b0;
        @(posedge clk);
        while (!wr_done) @(posedge clk);
    endtask

    task automatic run_read(input test_entry_t row);
        logic done;
        done = 1'b0;
        rd_cmd.addr <= row.addr;
        rd_cmd.len <= row.len;
        exp_resp <= row.resp;
        rd_cmd_valid <= 1'b1;
        @(posedge clk);
        while (!rd_cmd_ready) @(posedge clk);
        rd_cmd_valid <= 1'b0;
        // Ready low on roughly one cycle in three
        while (!done) begin
            rd_beat_ready <= ($urandom % 3) != 0;
            @(posedge clk);
            if (rd_beat_valid && rd_beat_ready && rd_beat.last) begin
                done = 1'b1;
            end
        end
        rd_beat_ready <= 1'b0;
    endtask

    initial begin
        int seed_ret;
        int idx;
        test_entry_t row;
        seed_ret = $urandom(SEED);
        rst = 1'b0;
        wr_cmd = '0;
        wr_cmd_valid = 1'b0;
        wr_data = 32'h0;
        wr_data_valid = 1'b0;
        rd_cmd = '0;
        rd_cmd_valid = 1'b0;
        rd_beat_ready = 1'b0;
        exp_resp = AXI_RESP_OKAY;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        for (idx = 0; idx < NUM_TESTS; idx++) begin
            row = table_row(idx);
            if (row.op == OP_WRITE) begin
                run_write(row);
            end else begin
                run_read(row);
            end
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d value, %0d flow, %0d assertion", value_errors, flow_errors,
                 axi_mem_top_inst.assertions_inst.assert_errors);
        if (value_errors + flow_errors + axi_mem_top_inst.assertions_inst.assert_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Budget of 20 cycles per table beat plus slack
    initial begin
        int total_beats;
        int idx;
        test_entry_t row;
        total_beats = 0;
        for (idx = 0; idx < NUM_TESTS; idx++) begin
            row = table_row(idx);
            total_beats += row.len + 1;
        end
        repeat (total_beats * 20 + 200) @(posedge clk);
        $display("Timeout: the command table did not finish within %0d cycles",
                 total_beats * 20 + 200);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: files.f
hw/axi_mem_pkg.sv
hw/bram_1r1w.sv
hw/data_ram.sv
hw/burst_writer.sv
hw/burst_reader.sv
hw/axi_mem_top.sv
sim/axi_mem_assertions.sv
sim/axi_mem_checker.sv
sim/axi_mem_tb.sv
